// File: hdl/i2c_pkg.sv
package i2c_pkg;

    typedef logic [6:0] dev_addr_t;   // 7-bit slave address, not shifted
    typedef logic [7:0] byte_t;
    typedef logic [7:0] step_t;       // quarter-bit step within one operation
    typedef logic [2:0] bit_idx_t;    // bit of a byte, msb first on the bus

    typedef enum logic [1:0] {
        op_idle,
        op_write,
        op_read
    } op_t;

    // one bus action per quarter-bit step
    typedef enum logic [3:0] {
        act_none,
        act_sda_low,
        act_sda_high,
        act_scl_low,
        act_scl_high,
        act_load_dev_wr,   // the four loads also pull scl low
        act_load_dev_rd,
        act_load_reg,
        act_load_data,
        act_drive_bit,
        act_release,
        act_sample,        // releases sda as well
        act_capture        // scl low, received byte to output
    } act_t;

    // transmit byte slot: 8 bits of 4 steps, then ack and the closing load
    localparam step_t tx_slot_len     = 8'd36;
    localparam step_t slot_dev_start  = 8'd2;
    localparam step_t slot_reg_start  = 8'd38;
    localparam step_t slot_data_start = 8'd74;   // write only
    localparam step_t slot_rd_start   = 8'd78;   // read address after repeated start

    // receive window of a read
    localparam step_t rx_start        = 8'd115;
    localparam step_t rx_capture      = 8'd145;

    localparam step_t write_last_step = 8'd113;
    localparam step_t read_last_step  = 8'd153;

endpackage

// File: hdl/i2c_tick_gen.sv
`timescale 1ns/1ps

module i2c_tick_gen #(
    parameter int quarter_len = 125
) (
    input  logic sclk,
    input  logic nrst,
    output logic tick
);

    logic [31:0] cnt;   // free running, wraps every quarter bit

    always_ff @(posedge sclk or negedge nrst) begin
        if (!nrst)
            cnt <= '0;
        else if (cnt == 32'(quarter_len - 1))
            cnt <= '0;
        else
            cnt <= cnt + 32'd1;
    end

    // registered one below the max so it lines up with the wrap
    always_ff @(posedge sclk or negedge nrst) begin
        if (!nrst)
            tick <= 1'b0;
        else
            tick <= (cnt == 32'(quarter_len - 2));
    end

endmodule

// File: hdl/i2c_step_decode.sv
`timescale 1ns/1ps

module i2c_step_decode (
    input  logic               sclk,
    input  logic               nrst,
    input  logic               tick,
    input  logic               write_trigger,
    input  logic               read_trigger,
    output i2c_pkg::op_t       op,
    output i2c_pkg::act_t      act,
    output i2c_pkg::bit_idx_t  bit_idx,
    output logic               step_last
);
    import i2c_pkg::*;

    step_t step;
    step_t rel;      // offset inside the current byte slot
    logic  at_last;

    function automatic logic in_slot(input step_t s, input step_t start);
        return (s >= start) && ((s - start) < tx_slot_len);
    endfunction

    // bit, ack, then whatever closes the slot
    function automatic act_t tx_slot_act(input step_t r, input act_t close_act);
        act_t a;
        a = act_none;
        if (r < 8'd32) begin
            case (r[1:0])
                2'd0:    a = act_drive_bit;
                2'd1:    a = act_scl_high;
                2'd3:    a = act_scl_low;
                default: a = act_none;
            endcase
        end else if (r == 8'd32) begin
            a = act_release;   // slave ack slot, not checked
        end else if (r == 8'd33) begin
            a = act_scl_high;
        end else if (r == tx_slot_len - 8'd1) begin
            a = close_act;
        end
        return a;
    endfunction

    function automatic act_t rx_slot_act(input step_t r);
        act_t a;
        case (r[1:0])
            2'd0:    a = act_scl_high;
            2'd1:    a = act_sample;
            2'd2:    a = (r[4:2] == 3'd7) ? act_capture : act_scl_low;
            default: a = act_none;
        endcase
        return a;
    endfunction

    assign at_last = (op == op_write && step == write_last_step) ||
                     (op == op_read && step == read_last_step);
    assign step_last = tick && at_last;

    always_ff @(posedge sclk or negedge nrst) begin
        if (!nrst) begin
            op   <= op_idle;
            step <= '0;
        end else if (op == op_idle) begin
            step <= '0;
            if (write_trigger ^ read_trigger)   // both at once is ignored
                op <= write_trigger ? op_write : op_read;
        end else if (tick) begin
            if (at_last) begin
                op   <= op_idle;
                step <= '0;
            end else begin
                step <= step + 8'd1;
            end
        end
    end

    always_comb begin
        rel = '0;
        act = act_none;
        if (op != op_idle && in_slot(step, slot_dev_start)) begin
            rel = step - slot_dev_start;
            act = tx_slot_act(rel, act_load_reg);
        end else if (op == op_write && in_slot(step, slot_reg_start)) begin
            rel = step - slot_reg_start;
            act = tx_slot_act(rel, act_load_data);
        end else if (op == op_write && in_slot(step, slot_data_start)) begin
            rel = step - slot_data_start;
            act = tx_slot_act(rel, act_scl_low);
        end else if (op == op_read && in_slot(step, slot_reg_start)) begin
            rel = step - slot_reg_start;
            act = tx_slot_act(rel, act_scl_low);
        end else if (op == op_read && in_slot(step, slot_rd_start)) begin
            rel = step - slot_rd_start;
            act = tx_slot_act(rel, act_scl_low);
        end else if (op == op_read && step >= rx_start && step <= rx_capture) begin
            rel = step - rx_start;
            act = rx_slot_act(rel);
        end else if (op == op_write) begin
            case (step)
                8'd0:    act = act_sda_low;       // start
                8'd1:    act = act_load_dev_wr;
                8'd110:  act = act_sda_low;       // stop
                8'd111:  act = act_scl_high;
                8'd112:  act = act_sda_high;
                default: act = act_none;
            endcase
        end else if (op == op_read) begin
            case (step)
                8'd0:    act = act_sda_low;
                8'd1:    act = act_load_dev_wr;
                8'd74:   act = act_sda_high;      // repeated start
                8'd75:   act = act_scl_high;
                8'd76:   act = act_sda_low;
                8'd77:   act = act_load_dev_rd;
                8'd146:  act = act_sda_high;      // master nack
                8'd147:  act = act_scl_high;
                8'd149:  act = act_scl_low;
                8'd150:  act = act_sda_low;       // stop
                8'd151:  act = act_scl_high;
                8'd152:  act = act_sda_high;
                default: act = act_none;
            endcase
        end
    end

    assign bit_idx = 3'd7 - rel[4:2];

endmodule

// File: hdl/i2c_bus_exec.sv
`timescale 1ns/1ps

module i2c_bus_exec (
    input  logic               sclk,
    input  logic               nrst,
    input  logic               tick,
    input  i2c_pkg::act_t      act,
    input  i2c_pkg::bit_idx_t  bit_idx,
    input  i2c_pkg::dev_addr_t equi_addr,
    input  i2c_pkg::byte_t     reg_addr,
    input  i2c_pkg::byte_t     write_byte,
    output logic               scl_low,
    output logic               sda_low
);
    import i2c_pkg::*;

    byte_t tx_byte;   // byte currently going out, msb first

    always_ff @(posedge sclk) begin
        if (tick) begin
            case (act)
                act_load_dev_wr: tx_byte <= {equi_addr, 1'b0};
                act_load_dev_rd: tx_byte <= {equi_addr, 1'b1};
                act_load_reg:    tx_byte <= reg_addr;
                act_load_data:   tx_byte <= write_byte;
                default:         tx_byte <= tx_byte;
            endcase
        end
    end

    // open-drain line state, 1 pulls the line low
    always_ff @(posedge sclk or negedge nrst) begin
        if (!nrst) begin
            scl_low <= 1'b0;
            sda_low <= 1'b0;
        end else if (tick) begin
            case (act)
                act_sda_low:
                    sda_low <= 1'b1;
                act_sda_high,
                act_release,
                act_sample:
                    sda_low <= 1'b0;
                act_drive_bit:
                    sda_low <= ~tx_byte[bit_idx];
                act_scl_high:
                    scl_low <= 1'b0;
                act_scl_low,
                act_load_dev_wr,
                act_load_dev_rd,
                act_load_reg,
                act_load_data,
                act_capture:
                    scl_low <= 1'b1;
                default: begin
                    scl_low <= scl_low;   // act_none holds both lines
                    sda_low <= sda_low;
                end
            endcase
        end
    end

endmodule

// File: hdl/i2c_read_result.sv
`timescale 1ns/1ps

module i2c_read_result (
    input  logic               sclk,
    input  logic               nrst,
    input  logic               tick,
    input  logic               sda_in,
    input  i2c_pkg::act_t      act,
    input  i2c_pkg::bit_idx_t  bit_idx,
    input  i2c_pkg::op_t       op,
    input  logic               step_last,
    output i2c_pkg::byte_t     read_byte,
    output logic               write_done,
    output logic               read_done
);
    import i2c_pkg::*;

    byte_t rx_byte;

    // first sample of a byte presets the lower bits to ones
    always_ff @(posedge sclk) begin
        if (tick && act == act_sample) begin
            if (bit_idx == 3'd7)
                rx_byte <= {sda_in, 7'h7f};
            else
                rx_byte[bit_idx] <= sda_in;
        end
    end

    always_ff @(posedge sclk or negedge nrst) begin
        if (!nrst)
            read_byte <= 8'hfd;
        else if (tick && act == act_capture)
            read_byte <= rx_byte;   // held until the next read
    end

    always_ff @(posedge sclk or negedge nrst) begin
        if (!nrst) begin
            write_done <= 1'b0;
            read_done  <= 1'b0;
        end else begin
            write_done <= step_last && (op == op_write);
            read_done  <= step_last && (op == op_read);
        end
    end

endmodule

// File: hdl/i2c_reg_master.sv
`timescale 1ns/1ps

module i2c_reg_master #(
    parameter int sys_clk_freq = 50_000_000,
    parameter int scl_freq     = 400_000
) (
    input  logic               sclk,
    input  logic               nrst,
    input  i2c_pkg::dev_addr_t equi_addr,
    input  i2c_pkg::byte_t     reg_addr,
    input  i2c_pkg::byte_t     write_byte,
    input  logic               write_trigger,
    input  logic               read_trigger,
    output i2c_pkg::byte_t     read_byte,
    output logic               write_done,
    output logic               read_done,
    output wire                scl,
    inout  wire                sda
);
    import i2c_pkg::*;

    logic     tick;
    op_t      op;
    act_t     act;
    bit_idx_t bit_idx;
    logic     step_last;
    logic     scl_low;
    logic     sda_low;
    logic     sda_in;

    // open-drain pads, released lines float high on the pull-ups
    assign scl    = scl_low ? 1'b0 : 1'bz;
    assign sda    = sda_low ? 1'b0 : 1'bz;
    assign sda_in = sda;

    i2c_tick_gen #(
        .quarter_len (sys_clk_freq / (4 * scl_freq))
    ) u_tick_gen (
        .sclk (sclk),
        .nrst (nrst),
        .tick (tick)
    );

    i2c_step_decode u_step_decode (
        .sclk          (sclk),
        .nrst          (nrst),
        .tick          (tick),
        .write_trigger (write_trigger),
        .read_trigger  (read_trigger),
        .op            (op),
        .act           (act),
        .bit_idx       (bit_idx),
        .step_last     (step_last)
    );

    i2c_bus_exec u_bus_exec (
        .sclk       (sclk),
        .nrst       (nrst),
        .tick       (tick),
        .act        (act),
        .bit_idx    (bit_idx),
        .equi_addr  (equi_addr),
        .reg_addr   (reg_addr),
        .write_byte (write_byte),
        .scl_low    (scl_low),
        .sda_low    (sda_low)
    );

    i2c_read_result u_read_result (
        .sclk       (sclk),
        .nrst       (nrst),
        .tick       (tick),
        .sda_in     (sda_in),
        .act        (act),
        .bit_idx    (bit_idx),
        .op         (op),
        .step_last  (step_last),
        .read_byte  (read_byte),
        .write_done (write_done),
        .read_done  (read_done)
    );

endmodule

// File: bench/i2c_slave_model.sv
`timescale 1ns/1ps

module i2c_slave_model #(
    parameter logic [6:0] dev_addr = 7'h2a
) (
    input  logic sclk,        // oversampling clock, bus edges seen on its falling edge
    input  logic nrst,
    input  wire  scl,
    inout  wire  sda,
    output int   start_cnt,   // start and repeated start conditions
    output int   stop_cnt,
    output int   rise_cnt     // scl rising edges
);

    typedef enum logic [2:0] {
        st_idle,
        st_addr,
        st_reg,
        st_wdata,
        st_rdata,
        st_ignore
    } slave_state_t;

    logic [7:0]   mem [0:255];
    slave_state_t state;
    logic [3:0]   bit_cnt;   // scl rises within the current byte, 9th is the ack
    logic [7:0]   shift;
    logic [7:0]   tx_byte;
    logic [7:0]   ptr;       // register pointer, set by the register address byte
    logic         scl_q;
    logic         sda_q;
    logic         sda_drive_low;
    logic         master_nack;

    assign sda = sda_drive_low ? 1'b0 : 1'bz;

    always @(negedge sclk or negedge nrst) begin
        if (!nrst) begin
            state         <= st_idle;
            bit_cnt       <= '0;
            shift         <= '0;
            tx_byte       <= '0;
            ptr           <= '0;
            scl_q         <= 1'b1;
            sda_q         <= 1'b1;
            sda_drive_low <= 1'b0;
            master_nack   <= 1'b0;
            start_cnt     <= 0;
            stop_cnt      <= 0;
            rise_cnt      <= 0;
            for (int i = 0; i < 256; i++)
                mem[i] <= 8'(i * 29) ^ 8'h5a;
        end else begin
            scl_q <= scl;
            sda_q <= sda;
            if (scl && scl_q && sda_q && !sda) begin
                start_cnt     <= start_cnt + 1;
                state         <= st_addr;
                bit_cnt       <= '0;
                sda_drive_low <= 1'b0;
            end else if (scl && scl_q && !sda_q && sda) begin
                stop_cnt      <= stop_cnt + 1;
                state         <= st_idle;
                sda_drive_low <= 1'b0;
            end else if (scl && !scl_q) begin
                rise_cnt <= rise_cnt + 1;
                if (bit_cnt < 4'd8)
                    shift <= {shift[6:0], sda};
                else
                    master_nack <= sda;   // ack clock of a byte we sent
                bit_cnt <= bit_cnt + 4'd1;
            end else if (!scl && scl_q) begin
                if (bit_cnt == 4'd8) begin
                    // ack slot follows
                    case (state)
                        st_addr: begin
                            if (shift[7:1] == dev_addr)
                                sda_drive_low <= 1'b1;
                            else
                                state <= st_ignore;
                        end
                        st_reg: begin
                            ptr           <= shift;
                            sda_drive_low <= 1'b1;
                        end
                        st_wdata: begin
                            mem[ptr]      <= shift;
                            ptr           <= ptr + 8'd1;
                            sda_drive_low <= 1'b1;
                        end
                        default: sda_drive_low <= 1'b0;   // master acks our byte
                    endcase
                end else if (bit_cnt == 4'd9) begin
                    bit_cnt       <= '0;
                    sda_drive_low <= 1'b0;
                    if ((state == st_addr && shift[0]) ||
                        (state == st_rdata && !master_nack)) begin
                        state         <= st_rdata;
                        tx_byte       <= mem[ptr];
                        sda_drive_low <= ~mem[ptr][7];
                        ptr           <= ptr + 8'd1;
                    end else if (state == st_addr) begin
                        state <= st_reg;
                    end else if (state == st_reg) begin
                        state <= st_wdata;
                    end else if (state == st_rdata) begin
                        state <= st_ignore;   // nack ends the read
                    end
                end else if (state == st_rdata && bit_cnt != 4'd0) begin
                    sda_drive_low <= ~tx_byte[6];
                    tx_byte       <= {tx_byte[6:0], 1'b0};
                end
            end
        end
    end

endmodule

// File: bench/tb_i2c_reg_master.sv
`timescale 1ns/1ps

module tb_i2c_reg_master;
    import i2c_pkg::*;

    localparam int        sys_clk_freq   = 25_000_000;
    localparam int        scl_freq       = 1_000_000;
    localparam int        quarter_len    = sys_clk_freq / (4 * scl_freq);
    localparam int        timeout_cycles = 12000;   // ~12 ops of up to 154 ticks
    localparam dev_addr_t slave_addr     = 7'h2a;

    logic      sclk;
    logic      nrst;
    dev_addr_t equi_addr;
    byte_t     reg_addr;
    byte_t     write_byte;
    logic      write_trigger;
    logic      read_trigger;
    byte_t     read_byte;
    logic      write_done;
    logic      read_done;
    wire       scl_bus;
    wire       sda_bus;
    int        start_cnt;
    int        stop_cnt;
    int        rise_cnt;
    int        cycles = 0;
    int        wr_pulses;
    int        rd_pulses;
    byte_t     shadow [0:255];
    logic      written [0:255];
    byte_t     regs [0:3];
    integer    seed;
    logic [31:0] r;

    pullup (scl_bus);
    pullup (sda_bus);

    i2c_reg_master #(
        .sys_clk_freq (sys_clk_freq),
        .scl_freq     (scl_freq)
    ) UUT (
        .sclk          (sclk),
        .nrst          (nrst),
        .equi_addr     (equi_addr),
        .reg_addr      (reg_addr),
        .write_byte    (write_byte),
        .write_trigger (write_trigger),
        .read_trigger  (read_trigger),
        .read_byte     (read_byte),
        .write_done    (write_done),
        .read_done     (read_done),
        .scl           (scl_bus),
        .sda           (sda_bus)
    );

    i2c_slave_model #(.dev_addr(slave_addr)) slave (
        .sclk      (sclk),
        .nrst      (nrst),
        .scl       (scl_bus),
        .sda       (sda_bus),
        .start_cnt (start_cnt),
        .stop_cnt  (stop_cnt),
        .rise_cnt  (rise_cnt)
    );

    always #20 sclk = ~sclk;

    // done pulses, counted where outputs are stable
    always @(negedge sclk or negedge nrst) begin
        if (!nrst) begin
            wr_pulses <= 0;
            rd_pulses <= 0;
        end else begin
            if (write_done)
                wr_pulses <= wr_pulses + 1;
            if (read_done)
                rd_pulses <= rd_pulses + 1;
        end
    end

    always @(posedge sclk) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("Timeout: no end of test after %0d cycles", cycles);
            $display("Simulation FAILED");
            $fatal(1, "timeout");
        end
    end

    task automatic fail_check(input string msg);
        $display("Fail at %0d ns: %s", $time, msg);
        $display("Simulation FAILED");
        $fatal(1, "check failed");
    endtask

    task automatic launch(input logic is_read, input byte_t addr, input byte_t data);
        @(posedge sclk);
        reg_addr      <= addr;
        write_byte    <= data;
        write_trigger <= !is_read;
        read_trigger  <= is_read;
        @(posedge sclk);
        write_trigger <= 1'b0;
        read_trigger  <= 1'b0;
    endtask

    // triggers of both kinds while the master is busy
    task automatic poke_triggers();
        repeat (3) begin
            repeat (100) @(posedge sclk);
            write_trigger <= 1'b1;
            @(posedge sclk);
            write_trigger <= 1'b0;
            read_trigger  <= 1'b1;
            @(posedge sclk);
            read_trigger  <= 1'b0;
        end
    endtask

    task automatic wait_done(input logic is_read);
        do
            @(negedge sclk);
        while (!(is_read ? read_done : write_done));
        @(negedge sclk);
        assert (!write_done && !read_done)
            else fail_check("done pulse longer than one cycle");
    endtask

    task automatic run_op(input logic is_read, input byte_t addr, input byte_t data,
                          input logic poke_busy);
        int starts;
        int stops;
        int rises;
        int wr0;
        int rd0;
        starts = start_cnt;
        stops  = stop_cnt;
        rises  = rise_cnt;
        wr0    = wr_pulses;
        rd0    = rd_pulses;
        launch(is_read, addr, data);
        if (poke_busy)
            poke_triggers();
        wait_done(is_read);
        if (poke_busy)
            repeat (20 * quarter_len) @(negedge sclk);
        if (!is_read) begin
            shadow[addr]  = data;
            written[addr] = 1'b1;
        end else begin
            assert (read_byte == shadow[addr])
                else fail_check($sformatf("read of reg %02h gave %02h, expected %02h",
                                          addr, read_byte, shadow[addr]));
        end
        assert (wr_pulses - wr0 == int'(!is_read) && rd_pulses - rd0 == int'(is_read))
            else fail_check($sformatf("reg %02h: %0d write_done and %0d read_done pulses",
                                      addr, wr_pulses - wr0, rd_pulses - rd0));
        assert (slave.mem[addr] == shadow[addr])
            else fail_check($sformatf("slave reg %02h holds %02h, expected %02h",
                                      addr, slave.mem[addr], shadow[addr]));
        assert (start_cnt - starts == (is_read ? 2 : 1) && stop_cnt - stops == 1)
            else fail_check($sformatf("reg %02h: %0d starts and %0d stops seen",
                                      addr, start_cnt - starts, stop_cnt - stops));
        // 9 clocks per byte, plus repeated start and stop clocks
        assert (rise_cnt - rises == (is_read ? 38 : 28))
            else fail_check($sformatf("reg %02h: %0d scl rising edges seen",
                                      addr, rise_cnt - rises));
    endtask

    initial begin
        int starts;
        sclk          = 1'b0;
        nrst          = 1'b0;
        equi_addr     = slave_addr;
        reg_addr      = '0;
        write_byte    = '0;
        write_trigger = 1'b0;
        read_trigger  = 1'b0;
        seed          = 32'h40c13466;
        for (int i = 0; i < 256; i++) begin
            shadow[i]  = '0;
            written[i] = 1'b0;
        end
        repeat (2) @(posedge sclk);
        nrst <= 1'b1;

        // quiet bus after reset
        repeat (8) begin
            @(negedge sclk);
            assert (scl_bus === 1'b1 && sda_bus === 1'b1 && !write_done && !read_done &&
                    read_byte == 8'hfd)
                else fail_check("bus or outputs not idle after reset");
        end

        run_op(1'b0, 8'h3c, 8'ha5, 1'b0);
        run_op(1'b1, 8'h3c, 8'h00, 1'b0);
        run_op(1'b0, 8'hc7, 8'h18, 1'b1);
        run_op(1'b1, 8'hc7, 8'h00, 1'b1);

        // both triggers together start nothing
        starts = start_cnt;
        @(posedge sclk);
        write_trigger <= 1'b1;
        read_trigger  <= 1'b1;
        @(posedge sclk);
        write_trigger <= 1'b0;
        read_trigger  <= 1'b0;
        repeat (200 * quarter_len) begin
            @(negedge sclk);
            assert (scl_bus === 1'b1 && sda_bus === 1'b1 && !write_done && !read_done)
                else fail_check("bus activity or done pulse after simultaneous triggers");
        end
        assert (start_cnt == starts)
            else fail_check("start condition after simultaneous triggers");

        for (int i = 0; i < 4; i++) begin
            r       = $random(seed);
            regs[i] = r[7:0];
        end
        for (int n = 0; n < 6; n++) begin
            r = $random(seed);
            if (r[8] && written[regs[r[1:0]]])
                run_op(1'b1, regs[r[1:0]], 8'h00, 1'b0);
            else
                run_op(1'b0, regs[r[1:0]], r[31:24], 1'b0);
        end

        $display("Simulation PASSED");
        $finish;
    end

endmodule

// File: sources.f
hdl/i2c_pkg.sv
hdl/i2c_tick_gen.sv
hdl/i2c_step_decode.sv
hdl/i2c_bus_exec.sv
hdl/i2c_read_result.sv
hdl/i2c_reg_master.sv
bench/i2c_slave_model.sv
bench/tb_i2c_reg_master.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build the testbench with verilator, run it, and check the log
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_i2c_reg_master \
    --Mdir obj_dir -o sim_tb \
    -f sources.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "Simulation PASSED" sim.log; then
    exit 0
fi
exit 1
